// ==== build.f ====
+incdir+.
mem_pkg.sv
header_decode.sv
rom_slot.sv
slot_arbiter.sv
mem_map_top.sv
tb_sdram_model.sv
tb_mem_map.sv

// ==== header_decode.sv ====
// Header decoder, captures game settings from the ROM download header
`include "mem_config.svh"

module header_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output logic [7:0]  game_id,
    output logic        dec_en,
    output logic        dec_type,
    output logic        mcu_en,
    output logic        single_bank
);

    logic header_wr;
    logic dec1_en;      // First decoder
    logic dec2_en;      // Second decoder

    // Header bytes lead the download stream
    assign header_wr = downloading && ioctl_wr && ioctl_addr < 25'(`HEADER_LEN);

    always_ff @(posedge clk) begin
        if (rst) begin
            game_id  <= 8'd0;
            dec_type <= 1'b0;
            mcu_en   <= 1'b0;
            dec1_en  <= 1'b0;
            dec2_en  <= 1'b0;
        end else if (header_wr) begin
            case (ioctl_addr)
                25'h10: begin
                    dec1_en  <= |ioctl_dout[1:0];
                    dec_type <= ioctl_dout[1];
                end
                25'h11: dec2_en <= ioctl_dout[0];
                25'h13: mcu_en  <= ioctl_dout[0];
                25'h18: game_id <= ioctl_dout;
                default: ;
            endcase
        end
    end

    // Derived settings, one cycle behind the captured bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_en      <= 1'b0;
            single_bank <= 1'b0;
        end else begin
            dec_en      <= dec1_en | dec2_en;
            single_bank <= game_id[4];      // Games with one tile bank
        end
    end

endmodule

// ==== mem_config.svh ====
// Memory map configuration for the ROM-to-SDRAM mapper
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// SDRAM bank geometry, in 16-bit words
`define SDRAM_AW   22

// Client regions as word offsets in the bank
// Main ROM sits at the bottom of the bank
`define SND_START  22'h04_0000
`define GFX_START  22'h08_0000

// Client address widths
`define MAIN_AW    18   // 16-bit words
`define SND_AW     15   // Bytes
`define GFX_AW     17   // 32-bit words

// Download header and read burst
`define HEADER_LEN 32   // Leading bytes of the download
`define BURST_LEN  2    // 16-bit beats per read

`endif

// ==== mem_map_top.sv ====
// ROM mapper top level, three cached clients sharing one SDRAM bank
`include "mem_config.svh"

module mem_map_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 downloading,
    input  logic [24:0]          ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 ioctl_wr,
    input  logic [5:0]           tile_bank,
    // Main CPU
    input  logic                 main_cs,
    input  logic [`MAIN_AW-1:0]  main_addr,
    output logic                 main_ok,
    output logic [15:0]          main_data,
    // Sound CPU
    input  logic                 snd_cs,
    input  logic [`SND_AW-1:0]   snd_addr,
    output logic                 snd_ok,
    output logic [7:0]           snd_data,
    // Tile graphics
    input  logic                 gfx_cs,
    input  logic [`GFX_AW-1:0]   gfx_addr,
    output logic                 gfx_ok,
    output logic [31:0]          gfx_data,
    // SDRAM
    output logic                 sdram_rd,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  mem_pkg::word_t       data_read,
    // Game settings
    output logic [7:0]           game_id,
    output logic                 dec_en,
    output logic                 dec_type,
    output logic                 mcu_en
);

    logic                          single_bank;
    logic [mem_pkg::N_CLIENTS-1:0] req;
    logic [mem_pkg::N_CLIENTS-1:0] beat_valid;
    mem_pkg::word_t                beat_data;
    logic [`SDRAM_AW-1:0]          main_req_addr;  // Relative to each region
    logic [`SDRAM_AW-1:0]          snd_req_addr;
    logic [`SDRAM_AW-1:0]          gfx_req_addr;

    header_decode u_header (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .game_id     ( game_id     ),
        .dec_en      ( dec_en      ),
        .dec_type    ( dec_type    ),
        .mcu_en      ( mcu_en      ),
        .single_bank ( single_bank )
    );

    rom_slot #(.data_t(logic [15:0]), .AW(`MAIN_AW)) u_main (
        .clk(clk), .rst(rst), .cs(main_cs), .addr(main_addr),
        .ok(main_ok), .data(main_data),
        .req(req[mem_pkg::MAIN]), .req_addr(main_req_addr),
        .beat_valid(beat_valid[mem_pkg::MAIN]), .beat_data(beat_data)
    );

    rom_slot #(.data_t(logic [7:0]), .AW(`SND_AW)) u_snd (
        .clk(clk), .rst(rst), .cs(snd_cs), .addr(snd_addr),
        .ok(snd_ok), .data(snd_data),
        .req(req[mem_pkg::SND]), .req_addr(snd_req_addr),
        .beat_valid(beat_valid[mem_pkg::SND]), .beat_data(beat_data)
    );

    rom_slot #(.data_t(logic [31:0]), .AW(`GFX_AW)) u_gfx (
        .clk(clk), .rst(rst), .cs(gfx_cs), .addr(gfx_addr),
        .ok(gfx_ok), .data(gfx_data),
        .req(req[mem_pkg::GFX]), .req_addr(gfx_req_addr),
        .beat_valid(beat_valid[mem_pkg::GFX]), .beat_data(beat_data)
    );

    slot_arbiter u_arb (
        .clk         ( clk           ),
        .rst         ( rst           ),
        .downloading ( downloading   ),
        .req         ( req           ),
        .main_addr   ( main_req_addr ),
        .snd_addr    ( snd_req_addr  ),
        .gfx_addr    ( gfx_req_addr  ),
        .tile_bank   ( tile_bank     ),
        .single_bank ( single_bank   ),
        .sdram_rd    ( sdram_rd      ),
        .sdram_addr  ( sdram_addr    ),
        .sdram_ack   ( sdram_ack     ),
        .data_dst    ( data_dst      ),
        .data_rdy    ( data_rdy      ),
        .data_read   ( data_read     ),
        .beat_valid  ( beat_valid    ),
        .beat_data   ( beat_data     )
    );

endmodule

// ==== mem_pkg.sv ====
// Shared types for the ROM mapper: SDRAM word, client index and arbiter states
package mem_pkg;

    // One SDRAM data word
    typedef logic [15:0] word_t;

    localparam int N_CLIENTS = 3;

    // Client index, also the bit position in req and beat_valid
    typedef enum logic [1:0] {
        MAIN = 2'd0,
        SND  = 2'd1,
        GFX  = 2'd2
    } client_t;

    typedef enum logic [1:0] {
        IDLE,   // Waiting for a request
        REQ,    // Read held until ack
        BEATS   // Collecting data beats
    } arb_state_t;

endpackage

// ==== rom_slot.sv ====
// ROM slot, single-entry read cache between one client and the SDRAM arbiter
`include "mem_config.svh"

module rom_slot #(
    parameter type data_t = logic [15:0],
    parameter int  AW     = 18
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    output logic                 ok,
    output data_t                data,
    output logic                 req,
    output logic [`SDRAM_AW-1:0] req_addr,
    input  logic                 beat_valid,
    input  mem_pkg::word_t       beat_data
);

    localparam int DW  = $bits(data_t);
    localparam int NW  = (DW > 16) ? DW / 16 : 1;    // Beats kept in the line
    localparam int CW  = $clog2(`BURST_LEN + 1);
    localparam int SAW = `SDRAM_AW;

    logic [SAW-1:0]   word_addr;    // First word behind the current addr
    logic [SAW-1:0]   tag;
    logic             valid;
    logic             hit;
    logic             miss;
    logic [CW-1:0]    beat_cnt;
    logic             last_beat;
    logic [NW*16-1:0] line;

    // Geometry follows the client data width
    generate
        if (DW == 8) begin : g_byte
            assign word_addr = SAW'(addr[AW-1:1]);
            assign data      = data_t'(addr[0] ? line[15:8] : line[7:0]);
        end else if (DW == 16) begin : g_word
            assign word_addr = SAW'(addr);
            assign data      = data_t'(line);
        end else begin : g_long
            assign word_addr = SAW'({addr, 1'b0});  // Two words per entry
            assign data      = data_t'(line);       // Second beat on top
        end
    endgenerate

    assign hit       = valid && tag == word_addr;
    assign miss      = !req && cs && !hit;
    assign ok        = cs && hit;
    assign req_addr  = tag;
    assign last_beat = beat_cnt == CW'(`BURST_LEN - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            req      <= 1'b0;
            beat_cnt <= '0;
        end else if (miss) begin
            req      <= 1'b1;       // Old entry is dropped
            valid    <= 1'b0;
            beat_cnt <= '0;
        end else if (req && beat_valid) begin
            beat_cnt <= beat_cnt + CW'(1);
            if (last_beat) begin
                req   <= 1'b0;
                valid <= 1'b1;      // ok follows on the next cycle
            end
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (miss)
            tag <= word_addr;
        if (req && beat_valid && int'(beat_cnt) < NW)
            line[int'(beat_cnt)*16 +: 16] <= beat_data;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the ROM mapper testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_mem_map -o sim_mem_map
out=$(./obj_dir/sim_mem_map)
echo "$out"
if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== slot_arbiter.sv ====
// SDRAM read arbiter, round-robin grant over the ROM slots with tile banking
`include "mem_config.svh"

module slot_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          downloading,
    input  logic [mem_pkg::N_CLIENTS-1:0] req,
    input  logic [`SDRAM_AW-1:0]          main_addr,
    input  logic [`SDRAM_AW-1:0]          snd_addr,
    input  logic [`SDRAM_AW-1:0]          gfx_addr,
    input  logic [5:0]                    tile_bank,
    input  logic                          single_bank,
    output logic                          sdram_rd,
    output logic [`SDRAM_AW-1:0]          sdram_addr,
    input  logic                          sdram_ack,
    input  logic                          data_dst,
    input  logic                          data_rdy,
    input  mem_pkg::word_t                data_read,
    output logic [mem_pkg::N_CLIENTS-1:0] beat_valid,
    output mem_pkg::word_t                beat_data
);

    localparam int SAW = `SDRAM_AW;
    localparam int CW  = $clog2(`BURST_LEN + 1);
    localparam logic [SAW-1:0] MAIN_START = '0;

    mem_pkg::arb_state_t state;
    mem_pkg::client_t    grant;     // Current or last client served
    mem_pkg::client_t    next;
    logic                found;
    logic                start;
    logic [2:0]          gfx_bank;
    logic [SAW-1:0]      gfx_banked;
    logic [SAW-1:0]      abs_addr;
    logic [CW-1:0]       beat_cnt;
    logic [CW-1:0]       beat_idx;
    logic                last_beat;

    // gfx_addr counts words, so client bit 16 lands on bit 17
    assign gfx_bank   = single_bank  ? {2'b00, gfx_addr[17]} :
                        gfx_addr[17] ? tile_bank[5:3] : tile_bank[2:0];
    assign gfx_banked = SAW'({gfx_bank, gfx_addr[16:0]});

    // Round robin, search starts after the last grant
    always_comb begin
        int idx;
        next  = grant;
        found = 1'b0;
        for (int i = 1; i <= mem_pkg::N_CLIENTS; i++) begin
            idx = (int'(grant) + i) % mem_pkg::N_CLIENTS;
            if (!found && req[idx]) begin
                next  = mem_pkg::client_t'(idx);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        case (next)
            mem_pkg::SND: abs_addr = `SND_START + snd_addr;
            mem_pkg::GFX: abs_addr = `GFX_START + gfx_banked;
            default:      abs_addr = MAIN_START + main_addr;
        endcase
    end

    assign start     = state == mem_pkg::IDLE && found && !downloading;
    assign sdram_rd  = state == mem_pkg::REQ;
    assign beat_data = data_read;
    assign beat_idx  = data_dst ? '0 : beat_cnt;   // dst restarts the count
    assign last_beat = beat_idx == CW'(`BURST_LEN - 1);

    // Beats go to the granted slot only
    always_comb begin
        beat_valid = '0;
        if (state == mem_pkg::BEATS && data_rdy)
            beat_valid[grant] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= mem_pkg::IDLE;
            grant    <= mem_pkg::GFX;       // First round begins at MAIN
            beat_cnt <= '0;
        end else begin
            case (state)
                mem_pkg::IDLE:
                    if (start) begin
                        grant <= next;
                        state <= mem_pkg::REQ;
                    end
                mem_pkg::REQ:
                    if (sdram_ack) begin
                        beat_cnt <= '0;
                        state    <= mem_pkg::BEATS;
                    end
                mem_pkg::BEATS:
                    if (data_rdy) begin
                        beat_cnt <= beat_idx + CW'(1);
                        if (last_beat)
                            state <= mem_pkg::IDLE;
                    end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            sdram_addr <= abs_addr;     // Held through REQ
    end

endmodule

// ==== tb_mem_map.sv ====
// Testbench for the ROM mapper that drives the three clients and the download stream
`include "mem_config.svh"

module tb_mem_map;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 4000;   // 60 reads at up to 40 cycles plus margin

    logic                 clk;
    logic                 rst;
    logic                 downloading;
    logic [24:0]          ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic                 ioctl_wr;
    logic [5:0]           tile_bank;
    logic                 main_cs;
    logic [`MAIN_AW-1:0]  main_addr;
    logic                 main_ok;
    logic [15:0]          main_data;
    logic                 snd_cs;
    logic [`SND_AW-1:0]   snd_addr;
    logic                 snd_ok;
    logic [7:0]           snd_data;
    logic                 gfx_cs;
    logic [`GFX_AW-1:0]   gfx_addr;
    logic                 gfx_ok;
    logic [31:0]          gfx_data;
    logic                 sdram_rd;
    logic [`SDRAM_AW-1:0] sdram_addr;
    logic                 sdram_ack;
    logic                 data_dst;
    logic                 data_rdy;
    mem_pkg::word_t       data_read;
    logic [7:0]           game_id;
    logic                 dec_en;
    logic                 dec_type;
    logic                 mcu_en;

    logic [2:0] hit_exp;        // One bit per client while a repeat read runs
    logic       hdr_wr;
    logic [7:0] prev_dout;
    logic [7:0] gfx_seq;        // Keeps gfx addresses apart between reads
    int         beats_left;     // Beats still owed after an ack
    int         errors;
    int         reads;
    int         cycles;

    mem_map_top uut (.*);
    tb_sdram_model u_sdram (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic mem_pkg::word_t model_word(input logic [`SDRAM_AW-1:0] w);
        return w[15:0] ^ 16'hA5C3;
    endfunction

    function automatic logic [7:0] snd_expect(input logic [`SND_AW-1:0] a);
        mem_pkg::word_t w;
        w = model_word(`SND_START + `SDRAM_AW'(a[`SND_AW-1:1]));
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    // Bank field replaces client bit 16 and each gfx entry spans two words
    function automatic logic [31:0] gfx_expect(input logic [`GFX_AW-1:0] a,
                                               input logic [5:0] bank_reg, input logic sb);
        logic [2:0]           bank;
        logic [`SDRAM_AW-1:0] base;
        if (sb)
            bank = {2'b00, a[16]};
        else
            bank = a[16] ? bank_reg[5:3] : bank_reg[2:0];
        base = `GFX_START + `SDRAM_AW'({bank, a[15:0], 1'b0});
        return {model_word(base + `SDRAM_AW'(1)), model_word(base)};
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic log_fault(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    assign hdr_wr = downloading && ioctl_wr && ioctl_addr < 25'(`HEADER_LEN);

    always @(posedge clk) begin
        prev_dout <= ioctl_dout;
        if (rst)
            beats_left <= 0;
        else if (sdram_ack)
            beats_left <= `BURST_LEN;
        else if (data_rdy)
            beats_left <= beats_left - 1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a read never completed", cycles);
            $display("reads %0d, errors %0d", reads, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Header capture
    hdr_game_id: assert property (@(posedge clk) disable iff (rst)
        hdr_wr && ioctl_addr == 25'h18 |=> game_id == prev_dout)
        else flag_mismatch("game_id", 32'($sampled(game_id)), 32'($sampled(prev_dout)));
    hdr_mcu: assert property (@(posedge clk) disable iff (rst)
        hdr_wr && ioctl_addr == 25'h13 |=> mcu_en == prev_dout[0])
        else flag_mismatch("mcu_en", 32'($sampled(mcu_en)), 32'($sampled(prev_dout[0])));
    hdr_type: assert property (@(posedge clk) disable iff (rst)
        hdr_wr && ioctl_addr == 25'h10 |=> dec_type == prev_dout[1])
        else flag_mismatch("dec_type", 32'($sampled(dec_type)), 32'($sampled(prev_dout[1])));
    hdr_dec1: assert property (@(posedge clk) disable iff (rst)
        $past(hdr_wr && ioctl_addr == 25'h10 && |ioctl_dout[1:0], 2) |-> dec_en)
        else flag_mismatch("dec_en", 32'($sampled(dec_en)), 32'h1);
    hdr_dec2: assert property (@(posedge clk) disable iff (rst)
        $past(hdr_wr && ioctl_addr == 25'h11 && ioctl_dout[0], 2) |-> dec_en)
        else flag_mismatch("dec_en", 32'($sampled(dec_en)), 32'h1);
    hdr_high: assert property (@(posedge clk) disable iff (rst)
        downloading && ioctl_wr && ioctl_addr >= 25'(`HEADER_LEN)
        |=> $stable(game_id) && $stable(mcu_en) && $stable(dec_type))
        else log_fault("a byte past the header changed the game settings");

    // Read data against the SDRAM contents
    main_data_ok: assert property (@(posedge clk) disable iff (rst)
        main_ok |-> main_data == model_word(`SDRAM_AW'(main_addr)))
        else flag_mismatch("main_data", 32'($sampled(main_data)),
                           32'(model_word(`SDRAM_AW'($sampled(main_addr)))));
    snd_data_ok: assert property (@(posedge clk) disable iff (rst)
        snd_ok |-> snd_data == snd_expect(snd_addr))
        else flag_mismatch("snd_data", 32'($sampled(snd_data)),
                           32'(snd_expect($sampled(snd_addr))));
    gfx_data_ok: assert property (@(posedge clk) disable iff (rst)
        gfx_ok |-> gfx_data == gfx_expect(gfx_addr, tile_bank, game_id[4]))
        else flag_mismatch("gfx_data", $sampled(gfx_data),
                           gfx_expect($sampled(gfx_addr), $sampled(tile_bank),
                                      $sampled(game_id[4])));

    // SDRAM handshake
    rd_held: assert property (@(posedge clk) disable iff (rst)
        sdram_rd && !sdram_ack |=> sdram_rd && $stable(sdram_addr))
        else log_fault("sdram_rd dropped or sdram_addr moved before ack");
    ack_clean: assert property (@(posedge clk) disable iff (rst)
        sdram_ack |-> sdram_rd && beats_left == 0)
        else log_fault("ack without a read or before the last burst ended");
    beat_owed: assert property (@(posedge clk) disable iff (rst)
        data_rdy |-> beats_left > 0)
        else log_fault("data beat outside a burst");
    dst_first: assert property (@(posedge clk) disable iff (rst)
        data_rdy |-> data_dst == (beats_left == `BURST_LEN))
        else log_fault("data_dst not on the first beat of a burst");

    // Repeat reads and download blocking
    hit_main: assert property (@(posedge clk) disable iff (rst)
        hit_exp[0] && main_cs |-> main_ok)
        else log_fault("main repeat read did not hit");
    hit_snd: assert property (@(posedge clk) disable iff (rst)
        hit_exp[1] && snd_cs |-> snd_ok)
        else log_fault("sound repeat read did not hit");
    hit_gfx: assert property (@(posedge clk) disable iff (rst)
        hit_exp[2] && gfx_cs |-> gfx_ok)
        else log_fault("gfx repeat read did not hit");
    hit_no_rd: assert property (@(posedge clk) disable iff (rst)
        |hit_exp |-> !sdram_rd)
        else log_fault("sdram_rd rose for a repeat read");
    dl_block: assert property (@(posedge clk) disable iff (rst)
        downloading && !sdram_rd |=> !sdram_rd)
        else log_fault("new SDRAM read started while downloading");

    task automatic set_downloading(input logic v);
        @(posedge clk);
        #2;
        downloading = v;
    endtask

    task automatic write_byte(input logic [24:0] a, input logic [7:0] d);
        @(posedge clk);
        #2;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
    endtask

    task automatic read_main(input logic [`MAIN_AW-1:0] a);
        @(posedge clk);
        #2;
        main_addr = a;
        main_cs   = 1'b1;
        do
            @(negedge clk);
        while (!main_ok);
        @(posedge clk);
        #2;
        main_cs = 1'b0;
        reads++;
    endtask

    task automatic read_snd(input logic [`SND_AW-1:0] a);
        @(posedge clk);
        #2;
        snd_addr = a;
        snd_cs   = 1'b1;
        do
            @(negedge clk);
        while (!snd_ok);
        @(posedge clk);
        #2;
        snd_cs = 1'b0;
        reads++;
    endtask

    task automatic read_gfx(input logic [`GFX_AW-1:0] a);
        @(posedge clk);
        #2;
        gfx_addr = a;
        gfx_cs   = 1'b1;
        do
            @(negedge clk);
        while (!gfx_ok);
        @(posedge clk);
        #2;
        gfx_cs = 1'b0;
        reads++;
    endtask

    initial begin
        logic [`MAIN_AW-1:0] m_a;
        logic [`SND_AW-1:0]  s_a;
        logic [`GFX_AW-1:0]  g_a;
        void'($urandom(94778));
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        tile_bank   = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        hit_exp     = '0;
        gfx_seq     = '0;
        errors      = 0;
        reads       = 0;
        cycles      = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // Header bytes and then bytes past the header that alias them
        set_downloading(1'b1);
        write_byte(25'h10, 8'h02);
        write_byte(25'h11, 8'h00);
        write_byte(25'h13, 8'h01);
        write_byte(25'h18, 8'h25);
        write_byte(25'h38, 8'hFF);
        write_byte(25'h33, 8'h00);
        write_byte(25'h30, 8'h00);
        write_byte(25'h10, 8'h00);
        write_byte(25'h11, 8'h01);
        write_byte(25'h11, 8'h00);
        write_byte(25'h10, 8'h01);      // Low enable bit alone
        write_byte(25'h10, 8'h00);
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (dec_en == 1'b0) else flag_mismatch("dec_en", 32'(dec_en), 32'h0);
        set_downloading(1'b0);

        for (int i = 0; i < 6; i++)
            read_main(`MAIN_AW'($urandom));
        for (int i = 0; i < 6; i++)
            read_snd({14'($urandom), i[0]});    // Both byte lanes

        // Banked gfx reads with tile banks first and single-bank games after
        for (int sb = 0; sb < 2; sb++) begin
            set_downloading(1'b1);
            write_byte(25'h18, (sb != 0) ? 8'h15 : 8'h05);
            set_downloading(1'b0);
            repeat (3) @(posedge clk);
            for (int i = 0; i < 6; i++) begin
                @(posedge clk);
                #2;
                tile_bank = 6'($urandom);
                g_a = {1'($urandom), gfx_seq, 8'($urandom)};
                gfx_seq++;
                read_gfx(g_a);
            end
        end

        // All three clients overlapping
        for (int r = 0; r < 10; r++) begin
            m_a = `MAIN_AW'($urandom);
            s_a = `SND_AW'($urandom);
            g_a = {1'($urandom), gfx_seq, 8'($urandom)};
            gfx_seq++;
            fork
                begin
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    read_main(m_a);
                end
                begin
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    read_snd(s_a);
                end
                begin
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    read_gfx(g_a);
                end
            join
        end

        // Repeat of each client's last address
        hit_exp = 3'b001;
        read_main(m_a);
        hit_exp = 3'b010;
        read_snd(s_a);
        hit_exp = 3'b100;
        read_gfx(g_a);
        hit_exp = 3'b000;

        // Main miss held off by a download
        set_downloading(1'b1);
        fork
            read_main(18'h2BEEF);
            begin
                write_byte(25'h40, 8'hAA);
                repeat (8) @(posedge clk);
                #2;
                downloading = 1'b0;
            end
        join

        repeat (4) @(posedge clk);
        assert (beats_left == 0) else log_fault("last burst left unfinished");
        $display("reads %0d, errors %0d", reads, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== tb_sdram_model.sv ====
// SDRAM bank model, acknowledges reads after a random delay and returns address-derived bursts
`include "mem_config.svh"

module tb_sdram_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sdram_rd,
    input  logic [`SDRAM_AW-1:0] sdram_addr,
    output logic                 sdram_ack,
    output logic                 data_dst,
    output logic                 data_rdy,
    output mem_pkg::word_t       data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    // Contents of the bank, a function of the word address
    function automatic mem_pkg::word_t word_at(input logic [`SDRAM_AW-1:0] w);
        return w[15:0] ^ 16'hA5C3;
    endfunction

    initial begin
        logic [`SDRAM_AW-1:0] base;
        int unsigned          gap;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #2;
            if (!rst && sdram_rd) begin
                base = sdram_addr;
                gap  = $urandom_range(3, 0);      // Ack delay
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
                sdram_ack = 1'b1;
                @(posedge clk);
                #2;
                sdram_ack = 1'b0;
                for (int k = 0; k < `BURST_LEN; k++) begin
                    if (k > 0) begin
                        gap = $urandom_range(3, 1);   // Beat spacing
                        repeat (gap - 1) begin
                            @(posedge clk);
                            #2;
                        end
                    end
                    data_rdy  = 1'b1;
                    data_dst  = (k == 0);
                    data_read = word_at(base + `SDRAM_AW'(k));
                    @(posedge clk);
                    #2;
                    data_rdy = 1'b0;
                    data_dst = 1'b0;
                end
            end
        end
    end

endmodule
